//--- rtl/vgaPkg.sv
package vgaPkg;

  // counter coordinate, wide enough for hTotal
  typedef logic [9:0] screenCoord;

  // coordinate inside the canvas
  typedef logic [7:0] canvasCoord;

  // one color channel toward the video DAC
  typedef logic [3:0] colorChannel;

  // horizontal timing, in pixel clocks
  localparam screenCoord hActive = 10'd640;
  localparam screenCoord hFront = 10'd16;
  localparam screenCoord hSync = 10'd96;
  localparam screenCoord hTotal = 10'd800;

  // vertical timing, in lines
  localparam screenCoord vActive = 10'd480;
  localparam screenCoord vFront = 10'd10;
  localparam screenCoord vSync = 10'd2;
  localparam screenCoord vTotal = 10'd525;

  // canvas edge in pixels, square region at upper left
  localparam screenCoord canvasSize = 10'd256;

endpackage

//--- rtl/paintPkg.sv
package paintPkg;

  // pixel code held in the canvas
  typedef logic [2:0] colorCode;

  // one byte off the SPI link
  typedef logic [7:0] spiByte;

  // brush flag position in the third byte
  localparam int brushBit = 7;

  // palette: each code bit switches one channel fully on or off
  // bit 2 red, bit 1 green, bit 0 blue
  localparam logic [3:0] channelFull = 4'hF;
  localparam logic [3:0] channelOff = 4'h0;

  // command decoder states, one per byte of a transfer
  typedef enum logic [1:0] {
    waitX,
    waitY,
    waitColor
  } decodeState;

endpackage

//--- rtl/paintWriteIf.sv
`timescale 1ns/1ps

interface paintWriteIf
  import vgaPkg::*, paintPkg::*;
  ();

  // write strobe, one cycle per pixel
  logic brush;
  canvasCoord x;
  canvasCoord y;
  colorCode color;

  // decoder side produces the write
  modport decoder (output brush, x, y, color);

  // store side takes one write per clock, no back-pressure
  modport store (input brush, x, y, color);

endinterface

//--- rtl/spiReceiver.sv
`timescale 1ns/1ps

module spiReceiver
  import paintPkg::*;
  (
  input logic clk,
  input logic reset,
  input logic sck,
  input logic sdi,
  input logic csN,
  output logic byteValid,
  output spiByte rxByte,
  output logic frameActive
);

  // two-flop synchronizers for the async SPI pins
  logic sckMeta, sckSync, sckPrev;
  logic sdiMeta, sdiSync;
  logic csMeta, csSync;
  logic sckRise;
  logic [2:0] bitCount;
  spiByte shiftReg;

  always_ff @(posedge clk) begin
    if (reset) begin
      sckMeta <= 1'b0;
      sckSync <= 1'b0;
      sckPrev <= 1'b0;
      // chip select idles high
      csMeta <= 1'b1;
      csSync <= 1'b1;
    end else begin
      sckMeta <= sck;
      sckSync <= sckMeta;
      sckPrev <= sckSync;
      csMeta <= csN;
      csSync <= csMeta;
    end
  end

  // data pin needs no reset, only sampled inside a frame
  always_ff @(posedge clk) begin
    sdiMeta <= sdi;
    sdiSync <= sdiMeta;
  end

  // rising edge of the synchronized sck
  assign sckRise = sckSync & ~sckPrev;

  // bit counter and byte strobe
  always_ff @(posedge clk) begin
    if (reset || csSync) begin
      // deselect drops any partial byte
      bitCount <= '0;
      byteValid <= 1'b0;
    end else begin
      byteValid <= 1'b0;
      if (sckRise) begin
        bitCount <= bitCount + 3'd1;
        // eighth edge completes the byte
        if (bitCount == 3'd7) begin
          byteValid <= 1'b1;
        end
      end
    end
  end

  // MSB first, so shift in at the bottom
  always_ff @(posedge clk) begin
    if (sckRise && !csSync) begin
      shiftReg <= {shiftReg[6:0], sdiSync};
    end
  end

  // shift register is stable while byteValid is high
  assign rxByte = shiftReg;
  assign frameActive = ~csSync;

endmodule

//--- rtl/spiDecode.sv
`timescale 1ns/1ps

module spiDecode
  import paintPkg::*;
  (
  input logic clk,
  input logic reset,
  input logic byteValid,
  input spiByte rxByte,
  input logic frameActive,
  paintWriteIf.decoder wr
);

  decodeState state;

  // command sequencer, byte order x then y then color
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= waitX;
      wr.brush <= 1'b0;
    end else begin
      // strobe lasts a single cycle
      wr.brush <= 1'b0;
      if (!frameActive) begin
        // csN released mid-command, start over
        state <= waitX;
      end else if (byteValid) begin
        case (state)
          waitX: begin
            state <= waitY;
          end
          waitY: begin
            state <= waitColor;
          end
          waitColor: begin
            // brush clear means the transfer paints nothing
            wr.brush <= rxByte[brushBit];
            state <= waitX;
          end
          default: begin
            state <= waitX;
          end
        endcase
      end
    end
  end

  // payload latches, qualified only by state
  always_ff @(posedge clk) begin
    if (byteValid && frameActive) begin
      if (state == waitX) begin
        wr.x <= rxByte;
      end
      if (state == waitY) begin
        wr.y <= rxByte;
      end
      if (state == waitColor) begin
        // low three bits select the palette entry
        wr.color <= rxByte[2:0];
      end
    end
  end

endmodule

//--- rtl/vgaController.sv
`timescale 1ns/1ps

module vgaController
  import vgaPkg::*;
  (
  input logic clk,
  input logic reset,
  output logic hsync,
  output logic vsync,
  output logic blankB,
  output screenCoord x,
  output screenCoord y
);

  screenCoord hCount;
  screenCoord vCount;
  logic hSyncZone;
  logic vSyncZone;
  logic visible;

  // raster counters, 800 clocks by 525 lines
  always_ff @(posedge clk) begin
    if (reset) begin
      hCount <= '0;
      vCount <= '0;
    end else if (hCount == hTotal - 10'd1) begin
      hCount <= '0;
      // line done, step the line counter
      if (vCount == vTotal - 10'd1) begin
        vCount <= '0;
      end else begin
        vCount <= vCount + 10'd1;
      end
    end else begin
      hCount <= hCount + 10'd1;
    end
  end

  // sync pulse spans 656..751 horizontally
  assign hSyncZone = (hCount >= hActive + hFront) &&
                     (hCount < hActive + hFront + hSync);
  // lines 490 and 491
  assign vSyncZone = (vCount >= vActive + vFront) &&
                     (vCount < vActive + vFront + vSync);
  assign visible = (hCount < hActive) && (vCount < vActive);

  // registered, so these trail the counters by one clock
  // which lines them up with the store's read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      blankB <= 1'b0;
    end else begin
      // syncs are active low
      hsync <= ~hSyncZone;
      vsync <= ~vSyncZone;
      blankB <= visible;
    end
  end

  assign x = hCount;
  assign y = vCount;

endmodule

//--- rtl/pixelStore.sv
`timescale 1ns/1ps

module pixelStore
  import vgaPkg::*, paintPkg::*;
  (
  input logic clk,
  input screenCoord rx,
  input screenCoord ry,
  paintWriteIf.store wr,
  output colorCode pixelCode
);

  // canvas indexed [row][column]
  colorCode canvas [canvasSize][canvasSize];
  canvasCoord readX;
  canvasCoord readY;
  logic outside;

  // canvas powers up black
  initial begin
    foreach (canvas[row, col]) begin
      canvas[row][col] = '0;
    end
  end

  // low bits address the canvas, the range check covers the rest
  assign readX = rx[7:0];
  assign readY = ry[7:0];
  assign outside = (rx >= canvasSize) || (ry >= canvasSize);

  // one write per clock from the SPI side
  always_ff @(posedge clk) begin
    if (wr.brush) begin
      canvas[wr.y][wr.x] <= wr.color;
    end
  end

  // registered read
  // same-pixel write in this cycle is not seen until the next read
  always_ff @(posedge clk) begin
    if (outside) begin
      pixelCode <= '0;
    end else begin
      pixelCode <= canvas[readY][readX];
    end
  end

endmodule

//--- rtl/colorDecode.sv
`timescale 1ns/1ps

module colorDecode
  import vgaPkg::*, paintPkg::*;
  (
  input colorCode pixelCode,
  input logic blankB,
  output colorChannel r,
  output colorChannel g,
  output colorChannel b
);

  // one code bit per channel, forced dark while blanked
  always_comb begin
    r = channelOff;
    g = channelOff;
    b = channelOff;
    if (blankB) begin
      if (pixelCode[2]) begin
        r = channelFull;
      end
      if (pixelCode[1]) begin
        g = channelFull;
      end
      if (pixelCode[0]) begin
        b = channelFull;
      end
    end
  end

endmodule

//--- rtl/vgaPaintTop.sv
`timescale 1ns/1ps

module vgaPaintTop
  import vgaPkg::*, paintPkg::*;
  (
  input logic clk,
  input logic reset,
  input logic sck,
  input logic sdi,
  input logic csN,
  output logic hsync,
  output logic vsync,
  output logic blankB,
  output colorChannel rBlanked,
  output colorChannel gBlanked,
  output colorChannel bBlanked
);

  // SPI byte stream
  logic byteValid;
  spiByte rxByte;
  logic frameActive;

  // raster position and the code read there
  screenCoord vgaX;
  screenCoord vgaY;
  colorCode pixelCode;

  // pixel writes from the decoder into the canvas
  paintWriteIf wr ();

  spiReceiver spiReceiver (
    .clk, .reset, .sck, .sdi, .csN,
    .byteValid, .rxByte, .frameActive
  );

  spiDecode spiDecode (
    .clk, .reset, .byteValid, .rxByte, .frameActive,
    .wr(wr.decoder)
  );

  vgaController vgaController (
    .clk, .reset, .hsync, .vsync, .blankB,
    .x(vgaX), .y(vgaY)
  );

  pixelStore pixelStore (
    .clk, .rx(vgaX), .ry(vgaY),
    .wr(wr.store), .pixelCode
  );

  // blanking is applied inside the decoder
  colorDecode colorDecode (
    .pixelCode, .blankB,
    .r(rBlanked), .g(gBlanked), .b(bBlanked)
  );

endmodule

//--- testbench/paintTb.sv
`timescale 1ns/1ps

module paintTb
  import vgaPkg::*, paintPkg::*;
  ();

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
    logic [2:0] color;
    logic brush;
    logic abort;
  } paintCmd;

  localparam int numCmds = 16;
  localparam int lineCycles = int'(hTotal);
  localparam int frameLines = int'(vTotal);
  localparam int frameCycles = lineCycles * frameLines;
  // three frames of scan plus one frame of margin
  localparam int timeoutCycles = 4 * frameCycles;

  logic clk;
  logic reset;
  logic sck;
  logic sdi;
  logic csN;
  logic hsync;
  logic vsync;
  logic blankB;
  colorChannel rBlanked;
  colorChannel gBlanked;
  colorChannel bBlanked;

  paintCmd cmdTable [numCmds];
  logic [2:0] modelCanvas [256][256];
  logic [15:0] lfsrState;
  logic stimulusDone;
  int cycleCount = 0;

  vgaPaintTop UUT (
    .clk, .reset, .sck, .sdi, .csN,
    .hsync, .vsync, .blankB,
    .rBlanked, .gBlanked, .bBlanked
  );

  // 40 ns pixel clock
  always #20 clk = ~clk;

  // hung run guard
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: the three frame scan did not finish in %0d cycles", timeoutCycles);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  task automatic checkValue(input string name, input logic [3:0] actual,
                            input logic [3:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s actual %h expected %h", $time, name, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // galois form, taps 16,14,13,11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // one step per bit taken
  task automatic drawByte(output logic [7:0] value);
    value = '0;
    for (int i = 0; i < 8; i++) begin
      value = {value[6:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // channel full when its code bit is set
  function automatic logic [3:0] paletteChannel(input logic [2:0] code, input int bitIdx);
    return code[bitIdx] ? 4'hF : 4'h0;
  endfunction

  task automatic setEntry(input int idx, input logic [7:0] x, input logic [7:0] y,
                          input logic [2:0] color, input logic brush, input logic abort);
    cmdTable[idx] = {x, y, color, brush, abort};
  endtask

  task automatic buildTable();
    logic [7:0] rx;
    logic [7:0] ry;
    for (int row = 0; row < 256; row++) begin
      for (int col = 0; col < 256; col++) begin
        modelCanvas[row][col] = 3'd0;
      end
    end
    // canvas corners
    setEntry(0, 8'd0, 8'd0, 3'd7, 1'b1, 1'b0);
    setEntry(1, 8'd255, 8'd0, 3'd4, 1'b1, 1'b0);
    setEntry(2, 8'd0, 8'd255, 3'd2, 1'b1, 1'b0);
    setEntry(3, 8'd255, 8'd255, 3'd1, 1'b1, 1'b0);
    // same pixel three times, last one wins
    setEntry(4, 8'd10, 8'd20, 3'd3, 1'b1, 1'b0);
    setEntry(5, 8'd10, 8'd20, 3'd5, 1'b1, 1'b0);
    setEntry(6, 8'd10, 8'd20, 3'd6, 1'b1, 1'b0);
    // brush clear, fresh pixel and a painted one
    setEntry(7, 8'd100, 8'd100, 3'd7, 1'b0, 1'b0);
    setEntry(8, 8'd255, 8'd255, 3'd6, 1'b0, 1'b0);
    // aborted after two bytes
    setEntry(9, 8'd120, 8'd130, 3'd5, 1'b1, 1'b1);
    setEntry(10, 8'd0, 8'd0, 3'd1, 1'b1, 1'b1);
    // pseudo random positions
    for (int i = 11; i < numCmds; i++) begin
      drawByte(rx);
      drawByte(ry);
      setEntry(i, rx, ry, 3'((i % 7) + 1), 1'b1, 1'b0);
    end
  endtask

  // MSB first, 4 clocks low then 4 clocks high per bit
  task automatic sendByte(input logic [7:0] value);
    for (int i = 7; i >= 0; i--) begin
      @(negedge clk);
      sck = 1'b0;
      sdi = value[i];
      repeat (4) @(negedge clk);
      sck = 1'b1;
      repeat (3) @(negedge clk);
    end
    @(negedge clk);
    sck = 1'b0;
  endtask

  task automatic sendCmd(input paintCmd cmd);
    @(negedge clk);
    csN = 1'b0;
    repeat (4) @(negedge clk);
    sendByte(cmd.x);
    sendByte(cmd.y);
    if (!cmd.abort) begin
      sendByte({cmd.brush, 4'b0000, cmd.color});
    end
    // let the last byte strobe through before deselect
    repeat (8) @(negedge clk);
    csN = 1'b1;
    repeat (16) @(negedge clk);
    if (!cmd.abort && cmd.brush) begin
      modelCanvas[cmd.y][cmd.x] = cmd.color;
    end
  endtask

  // outputs seen now belong to position (h,v) of the previous clock
  task automatic checkPosition(input int h, input int v, input int frame);
    logic visible;
    logic inCanvas;
    logic [2:0] code;
    logic [3:0] expHsync;
    logic [3:0] expVsync;
    visible = (h < 640) && (v < 480);
    inCanvas = (h < 256) && (v < 256);
    expHsync = (h >= 656 && h <= 751) ? 4'd0 : 4'd1;
    expVsync = (v == 490 || v == 491) ? 4'd0 : 4'd1;
    checkValue("hsync", {3'b000, hsync}, expHsync);
    checkValue("vsync", {3'b000, vsync}, expVsync);
    checkValue("blankB", {3'b000, blankB}, {3'b000, visible});
    code = (visible && inCanvas) ? modelCanvas[v][h] : 3'd0;
    // canvas still being painted during the first frame
    if (!(visible && inCanvas && frame == 0)) begin
      checkValue("rBlanked", rBlanked, paletteChannel(code, 2));
      checkValue("gBlanked", gBlanked, paletteChannel(code, 1));
      checkValue("bBlanked", bBlanked, paletteChannel(code, 0));
    end
  endtask

  // stimulus, applied inside the first frame
  initial begin
    sck = 1'b0;
    sdi = 1'b0;
    csN = 1'b1;
    stimulusDone = 1'b0;
    lfsrState = 16'h0001;
    buildTable();
    wait (reset === 1'b0);
    for (int i = 0; i < numCmds; i++) begin
      sendCmd(cmdTable[i]);
    end
    stimulusDone = 1'b1;
  end

  // reset and raster scan checker
  initial begin
    int hPos;
    int vPos;
    int frameCount;
    clk = 1'b0;
    reset = 1'b1;
    hPos = 0;
    vPos = 0;
    frameCount = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    // still the reset values before the first active edge
    checkValue("hsync", {3'b000, hsync}, 4'd1);
    checkValue("vsync", {3'b000, vsync}, 4'd1);
    checkValue("blankB", {3'b000, blankB}, 4'd0);
    checkValue("rBlanked", rBlanked, 4'd0);
    checkValue("gBlanked", gBlanked, 4'd0);
    checkValue("bBlanked", bBlanked, 4'd0);
    while (frameCount < 3) begin
      @(posedge clk);
      @(negedge clk);
      checkPosition(hPos, vPos, frameCount);
      if (hPos == lineCycles - 1) begin
        hPos = 0;
        if (vPos == frameLines - 1) begin
          vPos = 0;
          frameCount++;
        end else begin
          vPos++;
        end
      end else begin
        hPos++;
      end
    end
    if (stimulusDone) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("the SPI command table did not finish within three frames");
      $display("ERRORS FOUND");
      $fatal(1, "stimulus incomplete");
    end
  end

endmodule

//--- project.f
rtl/vgaPkg.sv
rtl/paintPkg.sv
rtl/paintWriteIf.sv
rtl/spiReceiver.sv
rtl/spiDecode.sv
rtl/vgaController.sv
rtl/pixelStore.sv
rtl/colorDecode.sv
rtl/vgaPaintTop.sv
testbench/paintTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, result taken from the simulation log
rm -f sim.log
verilator --binary --timing -f project.f --top-module paintTb -o paintSim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/paintSim > sim.log 2>&1
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" \
  || { echo "no result in sim.log"; exit 1; }
